/* src.f */
+incdir+verif
verilog/rv_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/fetch_unit.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/forward_unit.sv
verilog/execute_pipe.sv
verilog/cpu_top.sv
verif/cpu_tb.sv

/* verif/cpu_tb_tests.svh */
// Instruction encoders and directed test programs for the core testbench
// Included inside the cpu_tb module body
`ifndef cpu_tb_tests_svh
`define cpu_tb_tests_svh

  function automatic logic [2:0] f3_of(input int sel);
    case (sel)
      k_sll:        return 3'b001;
      k_slt:        return 3'b010;
      k_sltu:       return 3'b011;
      k_xor:        return 3'b100;
      k_srl, k_sra: return 3'b101;
      k_or:         return 3'b110;
      k_and:        return 3'b111;
      default:      return 3'b000;  // ADD and SUB
    endcase
  endfunction

  task automatic rr_instr(input int sel, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
    logic alt;
    alt = (sel == k_sub) || (sel == k_sra);  // funct7 bit 5
    prog.push_back({1'b0, alt, 5'b0, rs2, rs1, f3_of(sel), rd, 7'b0110011});
    retire(rd, ref_alu(sel, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic ri_instr(input int sel, input logic [4:0] rd, input logic [4:0] rs1,
                          input int imm);
    logic [11:0] imm12;
    imm12 = 12'(imm);
    if (sel == k_sra)
      imm12 = {7'b0100000, imm12[4:0]};
    else if (sel == k_sll || sel == k_srl)
      imm12 = {7'b0, imm12[4:0]};
    prog.push_back({imm12, rs1, f3_of(sel), rd, 7'b0010011});
    retire(rd, ref_alu(sel, model_regs[rs1], {{20{imm12[11]}}, imm12}));
  endtask

  // LUI, or AUIPC relative to the instruction's own address
  task automatic upper_instr(input logic is_auipc, input logic [4:0] rd, input logic [19:0] imm20);
    logic [31:0] base;
    base = is_auipc ? prog.size() * 4 : 0;
    prog.push_back({imm20, rd, is_auipc ? 7'b0010111 : 7'b0110111});
    retire(rd, base + {imm20, 12'b0});
  endtask

  task automatic raw_instr(input logic [31:0] instr);
    prog.push_back(instr);  // No register effect
  endtask

  task automatic nops(input int n);
    repeat (n) prog.push_back(nop);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    upper_instr(1'b0, rd, value[31:12] + value[11]);  // ADDI sign bit borrows from upper
    ri_instr(k_add, rd, rd, value[11:0]);
  endtask

  task automatic reset_and_fetch();
    start_program();
    nops(12);  // Nothing may retire
    run_program("reset_fetch");
  endtask

  task automatic reg_reg_ops();
    start_program();
    load_const(1, xorshift32());
    load_const(2, xorshift32());
    load_const(3, 32'h8000_0000 | xorshift32());  // Negative
    load_const(4, 32'hffff_ffdf);                 // Low five bits give 31
    load_const(15, 32'h8000_0000 | xorshift32());
    nops(3);
    for (int k = k_add; k <= k_and; k++)
      rr_instr(k, 5'(5 + k), 1, 2);
    rr_instr(k_sll, 16, 3, 4);
    rr_instr(k_sra, 17, 3, 4);
    rr_instr(k_srl, 18, 3, 4);
    rr_instr(k_slt, 19, 3, 1);  // Negative against random
    rr_instr(k_sltu, 20, 3, 1);
    rr_instr(k_slt, 21, 3, 15);  // Both negative
    rr_instr(k_sltu, 22, 15, 3);
    rr_instr(k_sub, 23, 1, 3);
    run_program("reg_reg");
  endtask

  task automatic imm_ops();
    start_program();
    load_const(1, xorshift32());
    load_const(2, 32'h8000_0000 | xorshift32());
    nops(3);
    ri_instr(k_add, 3, 1, -1234);
    ri_instr(k_add, 4, 2, 2047);
    ri_instr(k_add, 5, 1, -1024);  // Bit 30 set, still an add
    ri_instr(k_slt, 6, 2, -5);
    ri_instr(k_slt, 7, 1, 100);
    ri_instr(k_sltu, 8, 1, -1);    // Compares against all ones
    ri_instr(k_sltu, 9, 0, 1);
    ri_instr(k_xor, 10, 1, -1);
    ri_instr(k_xor, 11, 2, xorshift32());
    ri_instr(k_or, 12, 2, 12'h5a5);
    ri_instr(k_and, 13, 1, -256);
    ri_instr(k_sll, 14, 1, 31);
    ri_instr(k_srl, 16, 2, 7);
    ri_instr(k_sra, 17, 2, 31);
    ri_instr(k_sra, 18, 2, 4);
    run_program("imm");
  endtask

  task automatic forwarding_chains();
    start_program();
    load_const(1, xorshift32());
    load_const(2, xorshift32());
    nops(3);
    rr_instr(k_add, 3, 1, 2);
    rr_instr(k_xor, 4, 3, 1);  // Distance 1 on rs1
    rr_instr(k_sub, 5, 2, 4);  // Distance 1 on rs2
    rr_instr(k_and, 6, 4, 3);  // Distance 2 and 3
    ri_instr(k_add, 7, 5, 5);
    rr_instr(k_add, 7, 7, 6);  // Same register twice in a row
    rr_instr(k_add, 7, 7, 1);
    rr_instr(k_sll, 8, 7, 7);
    nops(1);
    rr_instr(k_or, 9, 7, 8);   // x7 through the write-through path
    ri_instr(k_add, 10, 1, 1);
    ri_instr(k_add, 10, 2, 2);
    rr_instr(k_add, 11, 10, 10);  // Newest x10 must win
    run_program("forwarding");
  endtask

  task automatic upper_imm_ops();
    start_program();
    upper_instr(1'b1, 1, 20'h00001);  // Address 0
    upper_instr(1'b0, 2, 20'hdead5);
    nops(2);
    upper_instr(1'b1, 3, 20'hfffff);  // Own address minus 4096
    upper_instr(1'b0, 4, 20'(xorshift32()));
    upper_instr(1'b1, 5, 20'(xorshift32()));
    rr_instr(k_add, 6, 4, 5);
    run_program("upper");
  endtask

  task automatic no_write_cases();
    start_program();
    load_const(1, xorshift32());
    load_const(2, xorshift32());
    rr_instr(k_add, 0, 1, 2);  // x0 targets retire nothing
    ri_instr(k_or, 0, 1, -1);
    upper_instr(1'b0, 0, 20'h12345);
    rr_instr(k_add, 3, 0, 1);
    raw_instr(32'h0000_a083);  // LW x1, 0(x1)
    raw_instr(32'h0020_a223);  // SW x2, 4(x1)
    raw_instr(32'h0000_0463);  // BEQ x0, x0, +8
    raw_instr(32'h0100_00ef);  // JAL x1, +16
    raw_instr(32'h0000_8167);  // JALR x2, 0(x1)
    rr_instr(k_or, 4, 1, 0);
    rr_instr(k_or, 5, 2, 0);
    rr_instr(k_add, 6, 0, 0);
    run_program("no_write");
  endtask

`endif

/* verif/cpu_tb.sv */
// Testbench for the five-stage RV32I integer core
// Loads directed programs into a NOP-filled instruction memory and checks every retire
module cpu_tb;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 10;
  localparam int mem_words    = 256;
  localparam int max_prog     = 64;  // Longest program a test may load
  localparam int drain_cycles = 8;   // Pipe depth plus margin
  localparam int num_tests    = 6;
  localparam int watchdog_cycles = num_tests * (reset_cycles + max_prog + drain_cycles + 2) + 100;
  localparam logic [31:0] nop = 32'h0000_0013;  // ADDI x0, x0, 0

  // Operation codes of the reference model
  localparam int k_add  = 0;
  localparam int k_sub  = 1;
  localparam int k_sll  = 2;
  localparam int k_slt  = 3;
  localparam int k_sltu = 4;
  localparam int k_xor  = 5;
  localparam int k_srl  = 6;
  localparam int k_sra  = 7;
  localparam int k_or   = 8;
  localparam int k_and  = 9;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] imem [mem_words];
  logic [31:0] prog [$];          // Program under construction
  logic [31:0] model_regs [32];   // Sequential register model
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          exp_cyc [$];       // Cycle after reset release of each retire
  logic [4:0]  got_rd [$];
  logic [31:0] got_data [$];
  int          got_cyc [$];
  int          cyc;
  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] rng_state = 32'h5165dfc5;

  cpu_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  assign imem_rdata = imem[imem_addr[9:2]];  // Combinational word read

  initial begin
    foreach (imem[i])
      imem[i] = nop;
  end

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // Retire monitor, samples mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      cyc = 0;
      if (wb_valid) begin
        other_errors++;
        $display("wb_valid went high while reset was asserted");
      end
    end else begin
      if (wb_valid) begin
        got_rd.push_back(wb_rd);
        got_data.push_back(wb_data);
        got_cyc.push_back(cyc);
      end
      cyc++;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // RV32I ALU rules, shift amount from the low five bits of b
  function automatic logic [31:0] ref_alu(input int sel, input logic [31:0] a,
                                          input logic [31:0] b);
    int sh;
    sh = b[4:0];
    case (sel)
      k_sub:  return a - b;
      k_sll:  return a << sh;
      k_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};  // Sign decides first
      k_sltu: return {31'b0, a < b};
      k_xor:  return a ^ b;
      k_srl:  return a >> sh;
      k_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      k_or:   return a | b;
      k_and:  return a & b;
      default: return a + b;
    endcase
  endfunction

  // Model write-back of the instruction just appended
  task automatic retire(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 0) begin
      model_regs[rd] = value;
      exp_rd.push_back(rd);
      exp_data.push_back(value);
      exp_cyc.push_back(prog.size() + 3);  // Fetched at index size-1, retires 4 cycles on
    end
  endtask

  task automatic start_program();
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_cyc.delete();
    foreach (model_regs[i])
      model_regs[i] = '0;
  endtask

  // Load, reset, run to drain and compare retires in order
  task automatic run_program(input string name);
    int n;
    if (prog.size() > max_prog) begin
      other_errors++;
      $display("%s: program has %0d words, more than %0d", name, prog.size(), max_prog);
    end
    @(posedge clk);
    rst <= 1'b1;
    foreach (imem[i])
      imem[i] <= (i < prog.size()) ? prog[i] : nop;
    got_rd.delete();
    got_data.delete();
    got_cyc.delete();
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < prog.size() + drain_cycles; i++) begin
      @(negedge clk);
      check_value($sformatf("%s fetch address %0d", name, i), i * 4, imem_addr);
    end
    @(posedge clk);
    if (got_rd.size() != exp_rd.size()) begin
      other_errors++;
      $display("%s: saw %0d retires but expected %0d", name, got_rd.size(), exp_rd.size());
    end
    n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("%s retire %0d rd", name, i), exp_rd[i], got_rd[i]);
      check_value($sformatf("%s retire %0d data", name, i), exp_data[i], got_data[i]);
      check_value($sformatf("%s retire %0d cycle", name, i), exp_cyc[i], got_cyc[i]);
    end
  endtask

  `include "cpu_tb_tests.svh"

  initial begin
    reset_and_fetch();
    reg_reg_ops();
    imm_ops();
    forwarding_chains();
    upper_imm_ops();
    no_write_cases();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: tests did not finish within %0d cycles", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* verilog/alu.sv */
// Integer ALU for the RV32I register and immediate operations
// Purely combinational, result valid in the same cycle
module alu (
  input  cpu_ctrl_pkg::alu_op_e        op,
  input  logic [rv_isa_pkg::xlen-1:0]  a,
  input  logic [rv_isa_pkg::xlen-1:0]  b,
  output logic [rv_isa_pkg::xlen-1:0]  y
);
  import rv_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  logic [shamt_w-1:0] shamt;

  assign shamt = b[shamt_w-1:0];  // Upper bits of B ignored for shifts

  always_comb begin
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sll:  y = a << shamt;
      alu_slt:  y = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
      alu_sltu: y = {{(xlen-1){1'b0}}, (a < b)};
      alu_xor:  y = a ^ b;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = $signed(a) >>> shamt;  // Sign bit fills from the left
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      default:  y = a + b;
    endcase
  end

endmodule

/* verilog/cpu_ctrl_pkg.sv */
// Control encodings passed between the decode and execute stages
// Imported by the decoder, execute pipeline, ALU and forwarding logic
package cpu_ctrl_pkg;

  // ALU operation carried down the pipe
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,   // Signed compare
    alu_sltu = 4'd4,   // Unsigned compare
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  // Where ALU operand A comes from
  typedef enum logic [1:0] {
    src_rs1  = 2'd0,   // Register, forwarding applies
    src_pc   = 2'd1,   // AUIPC
    src_zero = 2'd2    // LUI
  } src_a_e;

  // Bypass choice for one ALU operand
  typedef enum logic [1:0] {
    fwd_none = 2'd0,   // Value read in decode
    fwd_wb   = 2'd1,   // MEM/WB result
    fwd_mem  = 2'd2    // EX/MEM result, newest
  } fwd_sel_e;

endpackage

/* verilog/cpu_top.sv */
// Top level of the five-stage RV32I integer core
// Instruction port in, write-back retire port out
module cpu_top (
  input  logic                               clk,
  input  logic                               rst,
  output logic [rv_isa_pkg::xlen-1:0]        imem_addr,
  input  logic [rv_isa_pkg::xlen-1:0]        imem_rdata,
  output logic                               wb_valid,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  wb_rd,
  output logic [rv_isa_pkg::xlen-1:0]        wb_data
);
  import rv_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  logic [xlen-1:0]       id_instr;
  logic [xlen-1:0]       id_pc;
  alu_op_e               alu_op;
  src_a_e                src_a;
  logic                  use_imm;
  logic                  reg_write;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  fetch_unit fetch_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .id_instr   (id_instr),
    .id_pc      (id_pc)
  );

  // Decoder and register file both work on the IF/ID instruction
  instr_decoder decoder_i (
    .id_instr  (id_instr),
    .alu_op    (alu_op),
    .src_a     (src_a),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .imm       (imm),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2)
  );

  reg_file regs_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_valid),  // Write port doubles as the retire port
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  execute_pipe exec_i (
    .clk       (clk),
    .rst       (rst),
    .alu_op    (alu_op),
    .src_a     (src_a),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .imm       (imm),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .id_pc     (id_pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .wb_en     (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

endmodule

/* verilog/execute_pipe.sv */
// ID/EX, EX/MEM and MEM/WB stages with operand bypass and write-back
// MEM/WB drives both the register write port and the retire outputs
module execute_pipe (
  input  logic                               clk,
  input  logic                               rst,
  input  cpu_ctrl_pkg::alu_op_e              alu_op,
  input  cpu_ctrl_pkg::src_a_e               src_a,
  input  logic                               use_imm,
  input  logic                               reg_write,
  input  logic [rv_isa_pkg::xlen-1:0]        imm,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  rd,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs2,
  input  logic [rv_isa_pkg::xlen-1:0]        id_pc,
  input  logic [rv_isa_pkg::xlen-1:0]        rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0]        rs2_data,
  output logic                               wb_en,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  wb_rd,
  output logic [rv_isa_pkg::xlen-1:0]        wb_data
);
  import rv_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  // ID/EX
  alu_op_e               ex_alu_op;
  src_a_e                ex_src_a;
  logic                  ex_use_imm;
  logic                  ex_reg_write;
  logic [xlen-1:0]       ex_imm;
  logic [reg_addr_w-1:0] ex_rd;
  logic [reg_addr_w-1:0] ex_rs1;
  logic [reg_addr_w-1:0] ex_rs2;
  logic [xlen-1:0]       ex_pc;
  logic [xlen-1:0]       ex_rs1_data;
  logic [xlen-1:0]       ex_rs2_data;
  // EX stage
  fwd_sel_e              fwd_a;
  fwd_sel_e              fwd_b;
  logic [xlen-1:0]       rs1_fwd;
  logic [xlen-1:0]       rs2_fwd;
  logic [xlen-1:0]       op_a;
  logic [xlen-1:0]       op_b;
  logic [xlen-1:0]       alu_y;
  // EX/MEM
  logic                  mem_reg_write;
  logic [reg_addr_w-1:0] mem_rd;
  logic [xlen-1:0]       mem_result;

  // Bypass mux for one register operand
  function automatic logic [xlen-1:0] bypass(input fwd_sel_e sel,
                                             input logic [xlen-1:0] decoded);
    case (sel)
      fwd_mem: return mem_result;
      fwd_wb:  return wb_data;
      default: return decoded;
    endcase
  endfunction

  // Control bits, cleared by reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_reg_write  <= 1'b0;
      mem_reg_write <= 1'b0;
      wb_en         <= 1'b0;
    end else begin
      ex_reg_write  <= reg_write;
      mem_reg_write <= ex_reg_write;
      wb_en         <= mem_reg_write;  // Single-cycle retire strobe
    end
  end

  // Payload, follows the control bits
  always_ff @(posedge clk) begin
    ex_alu_op   <= alu_op;
    ex_src_a    <= src_a;
    ex_use_imm  <= use_imm;
    ex_imm      <= imm;
    ex_rd       <= rd;
    ex_rs1      <= rs1;
    ex_rs2      <= rs2;
    ex_pc       <= id_pc;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    mem_rd      <= ex_rd;
    mem_result  <= alu_y;
    wb_rd       <= mem_rd;
    wb_data     <= mem_result;
  end

  forward_unit fwd_i (
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .mem_rd        (mem_rd),
    .wb_rd         (wb_rd),
    .mem_reg_write (mem_reg_write),
    .wb_reg_write  (wb_en),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  always_comb begin
    rs1_fwd = bypass(fwd_a, ex_rs1_data);
    rs2_fwd = bypass(fwd_b, ex_rs2_data);
    case (ex_src_a)
      src_pc:   op_a = ex_pc;   // AUIPC
      src_zero: op_a = '0;      // LUI
      default:  op_a = rs1_fwd;
    endcase
    op_b = ex_use_imm ? ex_imm : rs2_fwd;
  end

  alu alu_i (
    .op (ex_alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

endmodule

/* verilog/fetch_unit.sv */
// Program counter and IF/ID register
// PC steps by one word every cycle, instruction read is combinational
module fetch_unit (
  input  logic                         clk,
  input  logic                         rst,
  output logic [rv_isa_pkg::xlen-1:0]  imem_addr,
  input  logic [rv_isa_pkg::xlen-1:0]  imem_rdata,
  output logic [rv_isa_pkg::xlen-1:0]  id_instr,
  output logic [rv_isa_pkg::xlen-1:0]  id_pc
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] pc;

  assign imem_addr = pc;  // Fetch address is the PC itself

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= '0;
      id_instr <= nop_instr;  // Pipe starts full of NOPs
      id_pc    <= '0;
    end else begin
      pc       <= pc + xlen'(instr_bytes);  // No redirects in this core
      id_instr <= imem_rdata;
      id_pc    <= pc;                       // Address of the captured instruction
    end
  end

  // Fetch never leaves word alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    imem_addr[1:0] == 2'b00)
    else $error("misaligned fetch address %h", imem_addr);

endmodule

/* verilog/forward_unit.sv */
// Bypass selection for the two ALU operands in EX
// The EX/MEM result is newer than MEM/WB and takes priority
module forward_unit (
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  ex_rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  ex_rs2,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  mem_rd,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  wb_rd,
  input  logic                               mem_reg_write,
  input  logic                               wb_reg_write,
  output cpu_ctrl_pkg::fwd_sel_e             fwd_a,
  output cpu_ctrl_pkg::fwd_sel_e             fwd_b
);
  import rv_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  // reg_write already excludes rd == 0
  function automatic fwd_sel_e pick_src(input logic [reg_addr_w-1:0] rs);
    if (mem_reg_write && (mem_rd == rs))
      return fwd_mem;
    if (wb_reg_write && (wb_rd == rs))
      return fwd_wb;
    return fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick_src(ex_rs1);
    fwd_b = pick_src(ex_rs2);
  end

endmodule

/* verilog/instr_decoder.sv */
// Decode stage control logic for the IF/ID instruction
// Produces ALU controls, register fields and the extended immediate
module instr_decoder (
  input  logic [rv_isa_pkg::xlen-1:0]        id_instr,
  output cpu_ctrl_pkg::alu_op_e              alu_op,
  output cpu_ctrl_pkg::src_a_e               src_a,
  output logic                               use_imm,
  output logic                               reg_write,
  output logic [rv_isa_pkg::xlen-1:0]        imm,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rd,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rs2
);
  import rv_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  opcode_e         opcode;
  funct3_e         funct3;
  logic            alt;    // funct7 bit 5
  logic            kept;   // Opcode is one the core executes
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;

  // funct3 to ALU op, SUB only exists in the register form
  function automatic alu_op_e map_op(input funct3_e f3, input logic alt_sel,
                                     input logic is_reg);
    case (f3)
      f3_add:  return (alt_sel && is_reg) ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return alt_sel ? alu_sra : alu_srl;  // SRAI carries the bit too
      f3_or:   return alu_or;
      f3_and:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign opcode = opcode_e'(id_instr[opcode_lsb +: opcode_w]);
  assign funct3 = funct3_e'(id_instr[funct3_lsb +: funct3_w]);
  assign alt    = id_instr[alt_bit];
  assign rd     = id_instr[rd_lsb +: reg_addr_w];
  assign rs1    = id_instr[rs1_lsb +: reg_addr_w];
  assign rs2    = id_instr[rs2_lsb +: reg_addr_w];

  assign imm_i = {{imm_i_lsb{id_instr[xlen-1]}}, id_instr[xlen-1:imm_i_lsb]};  // Sign extend
  assign imm_u = {id_instr[xlen-1:imm_u_lsb], {imm_u_lsb{1'b0}}};              // Low bits zero

  always_comb begin
    // Defaults describe a no-op
    alu_op  = alu_add;
    src_a   = src_rs1;
    use_imm = 1'b0;
    imm     = imm_i;
    kept    = 1'b0;
    case (opcode)
      op_reg: begin
        kept   = 1'b1;
        alu_op = map_op(funct3, alt, 1'b1);
      end
      op_imm: begin
        kept    = 1'b1;
        use_imm = 1'b1;
        alu_op  = map_op(funct3, alt, 1'b0);
      end
      op_lui: begin
        kept    = 1'b1;
        use_imm = 1'b1;
        src_a   = src_zero;  // 0 + imm
        imm     = imm_u;
      end
      op_auipc: begin
        kept    = 1'b1;
        use_imm = 1'b1;
        src_a   = src_pc;    // Own address + imm
        imm     = imm_u;
      end
      default: ;  // Loads, stores, branches, jumps and the rest write nothing
    endcase
  end

  // x0 is never a destination downstream
  assign reg_write = kept && (rd != '0);

  // Unknown instruction bits must not reach the controls
  always_comb begin
    a_ctrl_known: assert final (!$isunknown({alu_op, src_a, use_imm, reg_write}))
      else $error("decoder control unknown for %h", id_instr);
  end

endmodule

/* verilog/reg_file.sv */
// Integer register file, two combinational reads and one write
// A read of the register being written this cycle returns the new value
module reg_file (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs2,
  output logic [rv_isa_pkg::xlen-1:0]        rs1_data,
  output logic [rv_isa_pkg::xlen-1:0]        rs2_data,
  input  logic                               wb_en,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]  wb_rd,
  input  logic [rv_isa_pkg::xlen-1:0]        wb_data
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [num_regs];  // Entry 0 is never written

  // One read port with write-through
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
    if (wb_en && (wb_rd == addr))
      return wb_data;  // Same-cycle write wins
    return regs[addr];
  endfunction

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // Decode drops rd == 0 writes, so x0 stays zero
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb_en |-> (wb_rd != '0))
    else $error("write-back to x0");

endmodule

/* verilog/rv_isa_pkg.sv */
// RV32I instruction-set constants shared by the core
// Field positions, major opcodes and ALU funct3 codes
package rv_isa_pkg;

  localparam int xlen        = 32;  // Data and address width
  localparam int reg_addr_w  = 5;
  localparam int num_regs    = 32;
  localparam int shamt_w     = 5;   // Shift amount taken from operand B
  localparam int instr_bytes = 4;   // PC step per instruction

  // Field positions inside a 32-bit instruction
  localparam int opcode_lsb = 2;    // Bits 1:0 are always 2'b11
  localparam int opcode_w   = 5;
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int funct3_w   = 3;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int alt_bit    = 30;   // funct7 bit 5, picks SUB and SRA
  localparam int imm_i_lsb  = 20;   // I-type immediate is bits 31:20
  localparam int imm_u_lsb  = 12;   // U-type immediate is bits 31:12

  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;  // ADDI x0, x0, 0

  // Major opcodes the core executes, anything else is a no-op
  typedef enum logic [opcode_w-1:0] {
    op_imm   = 5'b00100,
    op_auipc = 5'b00101,
    op_reg   = 5'b01100,
    op_lui   = 5'b01101
  } opcode_e;

  typedef enum logic [funct3_w-1:0] {
    f3_add  = 3'b000,  // ADD, SUB, ADDI
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,  // SRL or SRA by alt bit
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } funct3_e;

endpackage
